/* compile.f */
+incdir+.
ex_pkg.sv
ex_logic_shift.sv
ex_arith.sv
ex_mul.sv
ex_hilo.sv
ex_ctrl.sv
ex_top.sv
tb_ex_top.sv

/* Bender.yml */
package:
  name: ex_unit

sources:
  - include_dirs:
      - .
    files:
      - ex_pkg.sv
      - ex_logic_shift.sv
      - ex_arith.sv
      - ex_mul.sv
      - ex_hilo.sv
      - ex_ctrl.sv
      - ex_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_ex_top.sv

/* tb_ex_top.sv */
`timescale 1ns/1ps
`include "ex_defines.svh"

module tb_ex_top import ex_pkg::*;
();

	localparam int ack_timeout = 20;

	logic    clk;
	logic    rst_n_i;
	logic    req_i;
	ex_req_t req_data_i;
	logic    ack_o;
	ex_rsp_t rsp_o;

	// one table row, hold counts extra cycles of back-pressure.
	typedef struct {
		ex_req_t req;
		int      hold;
	} row_t;

	row_t                   rows[$];
	logic [`EX_DWORD_W-1:0] model_hilo;
	int                     fail_count;
	int                     tests_passed;
	int                     tests_failed;
	bit                     hung;

	ex_top uut (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.req_i      (req_i),
		.req_data_i (req_data_i),
		.ack_o      (ack_o),
		.rsp_o      (rsp_o)
	);

	// 10 ns clock.
	always #5 clk = ~clk;

	// *************************************************************************
	// table construction.
	// *************************************************************************

	task automatic add_row(input ex_op_e op, input word_t r1, input word_t r2,
		input reg_addr_t wd, input logic wreg, input int hold);
		row_t r;
		r.req.op   = op;
		r.req.reg1 = r1;
		r.req.reg2 = r2;
		r.req.wd   = wd;
		r.req.wreg = wreg;
		r.hold     = hold;
		rows.push_back(r);
	endtask

	// hi/lo op, then read both halves back.
	task automatic queue_hilo_check(input ex_op_e op, input word_t r1, input word_t r2,
		input int hold);
		add_row(op, r1, r2, 5'd0, 1'b0, hold);
		add_row(OP_MFHI, '0, '0, 5'd2, 1'b1, 0);
		add_row(OP_MFLO, '0, '0, 5'd3, 1'b1, 0);
	endtask

	// *************************************************************************
	// reference model.
	// *************************************************************************

	// scan from the msb while bits match b.
	function automatic int lead_count(input word_t v, input logic b);
		int n;
		n = 0;
		while ((n < `EX_WORD_W) && (v[`EX_WORD_W-1-n] == b))
			n++;
		return n;
	endfunction

	task automatic model_step(input ex_req_t q, output ex_rsp_t exp);
		logic signed [`EX_WORD_W:0]    s_sum;
		logic signed [`EX_DWORD_W-1:0] s_prod;
		logic [`EX_DWORD_W-1:0]        u_prod;
		word_t                         ones;
		logic [`EX_SHAMT_W-1:0]        sh;
		ones   = '1;
		sh     = q.reg1[`EX_SHAMT_W-1:0];
		s_prod = $signed(q.reg1) * $signed(q.reg2);
		u_prod = {{`EX_WORD_W{1'b0}}, q.reg1} * {{`EX_WORD_W{1'b0}}, q.reg2};
		exp.wdata = '0;
		exp.wd    = q.wd;
		exp.wreg  = q.wreg;
		exp.ov    = 1'b0;
		case (q.op)
			OP_OR: exp.wdata = q.reg1 | q.reg2;
			OP_AND: exp.wdata = q.reg1 & q.reg2;
			OP_NOR: exp.wdata = ~(q.reg1 | q.reg2);
			OP_XOR: exp.wdata = q.reg1 ^ q.reg2;
			OP_SLL: exp.wdata = q.reg2 << sh;
			OP_SRL: exp.wdata = q.reg2 >> sh;
			// logical shift plus a mask of sign bits.
			OP_SRA: exp.wdata = (q.reg2 >> sh) | (q.reg2[`EX_WORD_W-1] ? ~(ones >> sh) : '0);
			OP_ADD, OP_SUB:
			begin
				if (q.op == OP_ADD)
					s_sum = $signed(q.reg1) + $signed(q.reg2);
				else
					s_sum = $signed(q.reg1) - $signed(q.reg2);
				// 33 bit result, top two bits differ on overflow.
				exp.wdata = s_sum[`EX_WORD_W-1:0];
				exp.ov    = s_sum[`EX_WORD_W] ^ s_sum[`EX_WORD_W-1];
				if (exp.ov)
					exp.wreg = 1'b0;
			end
			OP_ADDU: exp.wdata = q.reg1 + q.reg2;
			OP_SUBU: exp.wdata = q.reg1 - q.reg2;
			OP_SLT: exp.wdata = ($signed(q.reg1) < $signed(q.reg2)) ? 1 : 0;
			OP_SLTU: exp.wdata = (q.reg1 < q.reg2) ? 1 : 0;
			OP_CLZ: exp.wdata = lead_count(q.reg1, 1'b0);
			OP_CLO: exp.wdata = lead_count(q.reg1, 1'b1);
			OP_MUL: exp.wdata = s_prod[`EX_WORD_W-1:0];
			OP_MULT: model_hilo = s_prod;
			OP_MULTU: model_hilo = u_prod;
			OP_MADD: model_hilo = model_hilo + s_prod;
			OP_MADDU: model_hilo = model_hilo + u_prod;
			OP_MSUB: model_hilo = model_hilo - s_prod;
			OP_MSUBU: model_hilo = model_hilo - u_prod;
			OP_MFHI: exp.wdata = model_hilo[`EX_DWORD_W-1:`EX_WORD_W];
			OP_MFLO: exp.wdata = model_hilo[`EX_WORD_W-1:0];
			OP_MTHI: model_hilo[`EX_DWORD_W-1:`EX_WORD_W] = q.reg1;
			OP_MTLO: model_hilo[`EX_WORD_W-1:0] = q.reg1;
			default: exp.wdata = '0;
		endcase
	endtask

	// *************************************************************************
	// four-phase handshake driver and checks.
	// *************************************************************************

	task automatic run_handshake(input int idx, input row_t r);
		ex_rsp_t exp;
		ex_rsp_t held;
		int      cycles;
		int      exp_lat;
		int      fails_before;
		fails_before = fail_count;
		// accumulate ops take the extra cycle.
		exp_lat = (r.req.op inside {OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU}) ? 3 : 2;
		model_step(r.req, exp);
		@(posedge clk);
		#1;
		req_data_i = r.req;
		req_i      = 1'b1;
		cycles     = 0;
		while (!ack_o && (cycles < ack_timeout))
		begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (!ack_o)
		begin
			$display("test %0d %s: ack did not arrive within %0d cycles",
				idx, r.req.op.name(), ack_timeout);
			fail_count++;
			tests_failed++;
			hung = 1'b1;
			return;
		end
		assert (cycles == exp_lat)
		else
		begin
			$display("[FAIL] %0t test %0d: ack after %0d cycles, expected %0d",
				$time, idx, cycles, exp_lat);
			fail_count++;
		end
		assert (rsp_o === exp)
		else
		begin
			$display("[FAIL] %0t test %0d %s: got %h/%0d/%b/%b, expected %h/%0d/%b/%b",
				$time, idx, r.req.op.name(), rsp_o.wdata, rsp_o.wd, rsp_o.wreg, rsp_o.ov,
				exp.wdata, exp.wd, exp.wreg, exp.ov);
			fail_count++;
		end
		// back-pressure, response must not move.
		held = rsp_o;
		repeat (r.hold)
		begin
			@(posedge clk);
			#1;
			assert ((ack_o === 1'b1) && (rsp_o === held))
			else
			begin
				$display("[FAIL] %0t test %0d: ack or rsp changed under back-pressure",
					$time, idx);
				fail_count++;
			end
		end
		req_i  = 1'b0;
		cycles = 0;
		while (ack_o && (cycles < ack_timeout))
		begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (ack_o)
		begin
			$display("test %0d %s: ack did not drop within %0d cycles after req fell",
				idx, r.req.op.name(), ack_timeout);
			fail_count++;
			tests_failed++;
			hung = 1'b1;
			return;
		end
		assert (cycles == 1)
		else
		begin
			$display("[FAIL] %0t test %0d: ack fell %0d cycles after req", $time, idx, cycles);
			fail_count++;
		end
		if (fail_count == fails_before)
			tests_passed++;
		else
			tests_failed++;
		$display("test %0d %s: %s", idx, r.req.op.name(),
			(fail_count == fails_before) ? "ok" : "FAILED");
	endtask

	// *************************************************************************
	// main sequence.
	// *************************************************************************

	initial
	begin
		clk          = 1'b0;
		rst_n_i      = 1'b0;
		req_i        = 1'b0;
		req_data_i   = '0;
		model_hilo   = '0;
		fail_count   = 0;
		tests_passed = 0;
		tests_failed = 0;
		hung         = 1'b0;
		void'($urandom(32'h4f7d_71ac));

		// logic and shifts, shamt 0 and 31 included.
		add_row(OP_OR, 32'hf0f0_1234, 32'h0f0f_4321, 5'd1, 1'b1, 0);
		add_row(OP_AND, $urandom(), $urandom(), 5'd4, 1'b1, 0);
		add_row(OP_NOR, 32'h0000_ffff, 32'h00ff_00ff, 5'd7, 1'b1, 0);
		add_row(OP_XOR, $urandom(), $urandom(), 5'd9, 1'b0, 0);
		add_row(OP_SLL, 32'd0, 32'hdead_beef, 5'd10, 1'b1, 0);
		add_row(OP_SLL, 32'd31, 32'h0000_0003, 5'd11, 1'b1, 0);
		add_row(OP_SRL, 32'd4, 32'h8000_00f0, 5'd12, 1'b1, 0);
		add_row(OP_SRL, 32'd31, 32'hffff_ffff, 5'd13, 1'b1, 0);
		add_row(OP_SRA, 32'd8, 32'h8123_4567, 5'd14, 1'b1, 0);
		add_row(OP_SRA, 32'd31, 32'h8000_0000, 5'd15, 1'b1, 0);
		add_row(OP_SRA, 32'd0, 32'hf000_0001, 5'd16, 1'b1, 0);
		// add, sub and compares, overflow corners.
		add_row(OP_ADD, 32'd5, 32'd7, 5'd17, 1'b1, 0);
		add_row(OP_ADD, 32'h7fff_ffff, 32'd1, 5'd18, 1'b1, 0);
		add_row(OP_ADD, 32'h8000_0000, 32'hffff_ffff, 5'd19, 1'b1, 0);
		add_row(OP_ADDU, 32'h7fff_ffff, 32'd1, 5'd20, 1'b1, 0);
		add_row(OP_SUB, 32'd10, 32'd3, 5'd21, 1'b1, 0);
		add_row(OP_SUB, 32'h8000_0000, 32'd1, 5'd22, 1'b1, 0);
		add_row(OP_SUB, 32'h7fff_ffff, 32'hffff_ffff, 5'd23, 1'b1, 0);
		add_row(OP_SUBU, 32'h8000_0000, 32'd1, 5'd24, 1'b1, 0);
		add_row(OP_ADD, $urandom(), $urandom(), 5'd25, 1'b1, 0);
		add_row(OP_SUB, $urandom(), $urandom(), 5'd26, 1'b1, 0);
		add_row(OP_SLT, 32'hffff_fffe, 32'd1, 5'd27, 1'b1, 0);
		add_row(OP_SLT, 32'd5, 32'd5, 5'd28, 1'b1, 0);
		add_row(OP_SLTU, 32'hffff_fffe, 32'd1, 5'd29, 1'b1, 0);
		add_row(OP_SLTU, 32'd1, 32'd2, 5'd30, 1'b1, 0);
		add_row(OP_CLZ, 32'd0, 32'd0, 5'd31, 1'b1, 0);
		add_row(OP_CLZ, 32'h0001_0000, 32'd0, 5'd1, 1'b1, 0);
		add_row(OP_CLO, 32'hffff_ffff, 32'd0, 5'd2, 1'b1, 0);
		add_row(OP_CLO, 32'hf000_0000, 32'd0, 5'd3, 1'b1, 0);
		// multiplies.
		queue_hilo_check(OP_MULT, $urandom(), $urandom(), 0);
		queue_hilo_check(OP_MULT, 32'hffff_fff9, 32'd3, 0);
		queue_hilo_check(OP_MULT, 32'h8000_0000, 32'h8000_0000, 0);
		queue_hilo_check(OP_MULTU, 32'hffff_ffff, 32'hffff_ffff, 0);
		add_row(OP_MUL, 32'hffff_fffd, 32'h0000_1000, 5'd5, 1'b1, 0);
		add_row(OP_MUL, $urandom(), $urandom(), 5'd6, 1'b1, 0);
		// moves and accumulation.
		queue_hilo_check(OP_MTHI, 32'h1234_5678, 32'd0, 0);
		queue_hilo_check(OP_MTLO, 32'hcafe_f00d, 32'd0, 0);
		queue_hilo_check(OP_MADD, $urandom(), $urandom(), 0);
		queue_hilo_check(OP_MADDU, 32'hffff_ffff, 32'd2, 0);
		queue_hilo_check(OP_MSUB, 32'hffff_fffd, 32'd5, 0);
		queue_hilo_check(OP_MSUBU, $urandom(), $urandom(), 0);
		// held requests.
		add_row(OP_OR, 32'h0bad_cafe, 32'h1000_0001, 5'd8, 1'b1, 5);
		queue_hilo_check(OP_MADD, 32'hffff_ff00, 32'd300, 4);
		add_row(OP_NOP, 32'd1, 32'd2, 5'd0, 1'b0, 0);

		// reset for 8 cycles.
		repeat (8) @(posedge clk);
		#1;
		rst_n_i = 1'b1;
		assert ((ack_o === 1'b0) && (rsp_o === '0))
		else
		begin
			$display("[FAIL] %0t reset: ack %b rsp %h", $time, ack_o, rsp_o);
			fail_count++;
		end
		if (fail_count == 0)
			tests_passed++;
		else
			tests_failed++;
		$display("test 0 reset: %s", (fail_count == 0) ? "ok" : "FAILED");

		for (int i = 0; (i < rows.size()) && !hung; i++)
			run_handshake(i + 1, rows[i]);

		$display("tests passed %0d, tests failed %0d, check errors %0d",
			tests_passed, tests_failed, fail_count);
		if (fail_count == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

/* ex_top.sv */
`timescale 1ns/1ps

module ex_top import ex_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n_i,
	input  logic    req_i,
	input  ex_req_t req_data_i,
	output logic    ack_o,
	output ex_rsp_t rsp_o
);

	// operands from control.
	ex_op_e op;
	word_t  reg1;
	word_t  reg2;

	// datapath results.
	word_t  logic_shift_res;
	word_t  arith_res;
	logic   ov;
	dword_t product;

	// hi/lo state and write port.
	hilo_t  hilo_q;
	hilo_t  hilo_d;
	logic   hilo_we;

	// *************************************************************************
	// control and sequencing.
	// *************************************************************************

	ex_ctrl u_ctrl (
		.clk               (clk),
		.rst_n_i           (rst_n_i),
		.req_i             (req_i),
		.req_data_i        (req_data_i),
		.ack_o             (ack_o),
		.rsp_o             (rsp_o),
		.op_o              (op),
		.reg1_o            (reg1),
		.reg2_o            (reg2),
		.logic_shift_res_i (logic_shift_res),
		.arith_res_i       (arith_res),
		.ov_i              (ov),
		.product_i         (product),
		.hilo_i            (hilo_q),
		.hilo_we_o         (hilo_we),
		.hilo_o            (hilo_d)
	);

	// *************************************************************************
	// datapath, all zero latency.
	// *************************************************************************

	ex_logic_shift u_logic_shift (
		.op_i   (op),
		.reg1_i (reg1),
		.reg2_i (reg2),
		.res_o  (logic_shift_res)
	);

	ex_arith u_arith (
		.op_i   (op),
		.reg1_i (reg1),
		.reg2_i (reg2),
		.res_o  (arith_res),
		.ov_o   (ov)
	);

	ex_mul u_mul (
		.op_i      (op),
		.reg1_i    (reg1),
		.reg2_i    (reg2),
		.product_o (product)
	);

	// hi/lo updates one edge after the enable.
	ex_hilo u_hilo (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.we_i    (hilo_we),
		.hilo_i  (hilo_d),
		.hilo_o  (hilo_q)
	);

endmodule

/* ex_ctrl.sv */
`timescale 1ns/1ps
`include "ex_defines.svh"

module ex_ctrl import ex_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n_i,
	input  logic    req_i,
	input  ex_req_t req_data_i,
	output logic    ack_o,
	output ex_rsp_t rsp_o,
	output ex_op_e  op_o,
	output word_t   reg1_o,
	output word_t   reg2_o,
	input  word_t   logic_shift_res_i,
	input  word_t   arith_res_i,
	input  logic    ov_i,
	input  dword_t  product_i,
	input  hilo_t   hilo_i,
	output logic    hilo_we_o,
	output hilo_t   hilo_o
);

	ex_state_e state_q;
	ex_state_e state_d;
	ex_req_t   req_q;
	ex_rsp_t   rsp_q;
	ex_rsp_t   rsp_d;
	dword_t    acc_q;
	logic      ack_q;
	logic      is_macc;
	logic      is_msub;
	logic      enter_done;

	// map an opcode to its result group.
	function automatic ex_grp_e grp_of(input ex_op_e op);
		case (op)
			OP_OR, OP_AND, OP_NOR, OP_XOR: return GRP_LOGIC;
			OP_SLL, OP_SRL, OP_SRA: return GRP_SHIFT;
			OP_ADD, OP_ADDU, OP_SUB, OP_SUBU: return GRP_ARITH;
			OP_SLT, OP_SLTU, OP_CLZ, OP_CLO: return GRP_ARITH;
			OP_MUL: return GRP_MUL;
			OP_MFHI, OP_MFLO: return GRP_MOVE;
			default: return GRP_NONE;
		endcase
	endfunction

	// captured operands feed the datapath directly.
	assign op_o   = req_q.op;
	assign reg1_o = req_q.reg1;
	assign reg2_o = req_q.reg2;
	assign ack_o  = ack_q;
	assign rsp_o  = rsp_q;

	// multiply-accumulate needs a second cycle.
	assign is_macc = req_q.op inside {OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU};
	assign is_msub = req_q.op inside {OP_MSUB, OP_MSUBU};
	assign enter_done = ((state_q == ST_EXEC) && !is_macc) || (state_q == ST_ACC);

	// *************************************************************************
	// handshake fsm.
	// *************************************************************************

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			ST_IDLE:
			begin
				if (req_i)
					state_d = ST_EXEC;
			end
			ST_EXEC:
			begin
				state_d = is_macc ? ST_ACC : ST_DONE;
			end
			ST_ACC:
			begin
				state_d = ST_DONE;
			end
			default:
			begin
				// wait for the requester to let go.
				if (!req_i)
					state_d = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			state_q <= ST_IDLE;
			ack_q   <= 1'b0;
			rsp_q   <= '0;
		end
		else
		begin
			state_q <= state_d;
			if (enter_done)
			begin
				ack_q <= 1'b1;
				rsp_q <= rsp_d;
			end
			else if ((state_q == ST_DONE) && !req_i)
				ack_q <= 1'b0;
		end
	end

	// request capture and accumulate temporary.
	always_ff @(posedge clk)
	begin
		if ((state_q == ST_IDLE) && req_i)
			req_q <= req_data_i;
		// msub variants accumulate the negated product.
		if (state_q == ST_EXEC)
			acc_q <= is_msub ? -product_i : product_i;
	end

	// *************************************************************************
	// response and hi/lo write data.
	// *************************************************************************

	always_comb
	begin
		rsp_d.wd   = req_q.wd;
		rsp_d.wreg = req_q.wreg;
		rsp_d.ov   = 1'b0;
		// signed overflow suppresses the write.
		if ((req_q.op inside {OP_ADD, OP_SUB}) && ov_i)
		begin
			rsp_d.wreg = 1'b0;
			rsp_d.ov   = 1'b1;
		end
		case (grp_of(req_q.op))
			GRP_LOGIC, GRP_SHIFT: rsp_d.wdata = logic_shift_res_i;
			GRP_ARITH: rsp_d.wdata = arith_res_i;
			GRP_MUL: rsp_d.wdata = product_i[`EX_WORD_W-1:0];
			GRP_MOVE: rsp_d.wdata = (req_q.op == OP_MFHI) ? hilo_i.hi : hilo_i.lo;
			default: rsp_d.wdata = '0;
		endcase
	end

	always_comb
	begin
		hilo_we_o = 1'b0;
		hilo_o    = hilo_i;
		if (state_q == ST_ACC)
		begin
			hilo_we_o = 1'b1;
			hilo_o    = hilo_t'(dword_t'(hilo_i) + acc_q);
		end
		else if (state_q == ST_EXEC)
		begin
			case (req_q.op)
				OP_MULT, OP_MULTU:
				begin
					hilo_we_o = 1'b1;
					hilo_o    = hilo_t'(product_i);
				end
				// only the named half changes.
				OP_MTHI:
				begin
					hilo_we_o = 1'b1;
					hilo_o.hi = req_q.reg1;
				end
				OP_MTLO:
				begin
					hilo_we_o = 1'b1;
					hilo_o.lo = req_q.reg1;
				end
				default: hilo_we_o = 1'b0;
			endcase
		end
	end

	// ack only answers a request that was held.
	assert property (@(posedge clk) disable iff (!rst_n_i)
		$rose(ack_o) |-> $past(req_i));

	// hi/lo commits on the edge into done, together with ack.
	assert property (@(posedge clk) disable iff (!rst_n_i)
		hilo_we_o |=> (state_q == ST_DONE) && ack_o);

endmodule

/* ex_hilo.sv */
`timescale 1ns/1ps

module ex_hilo import ex_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n_i,
	input  logic  we_i,
	input  hilo_t hilo_i,
	output hilo_t hilo_o
);

	// hi/lo pair, both words load together.
	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
			hilo_o <= '0;
		else if (we_i)
			hilo_o <= hilo_i;
	end

	// write data from the control side must be fully known.
	assert property (@(posedge clk) disable iff (!rst_n_i)
		we_i |-> !$isunknown(hilo_i));

endmodule

/* ex_mul.sv */
`timescale 1ns/1ps

module ex_mul import ex_pkg::*;
(
	input  ex_op_e op_i,
	input  word_t  reg1_i,
	input  word_t  reg2_i,
	output dword_t product_o
);

	logic   signed_op;
	word_t  mag1;
	word_t  mag2;
	dword_t prod_u;

	// signed forms multiply magnitudes.
	assign signed_op = op_i inside {OP_MUL, OP_MULT, OP_MADD, OP_MSUB};
	assign mag1 = (signed_op && reg1_i[$high(reg1_i)]) ? (~reg1_i + 1'b1) : reg1_i;
	assign mag2 = (signed_op && reg2_i[$high(reg2_i)]) ? (~reg2_i + 1'b1) : reg2_i;

	// full 64 bit unsigned product.
	assign prod_u = dword_t'(mag1) * dword_t'(mag2);

	// fix the sign when the operands disagree.
	assign product_o = (signed_op && (reg1_i[$high(reg1_i)] ^ reg2_i[$high(reg2_i)]))
		? (~prod_u + 1'b1) : prod_u;

endmodule

/* ex_arith.sv */
`timescale 1ns/1ps
`include "ex_defines.svh"

module ex_arith import ex_pkg::*;
(
	input  ex_op_e op_i,
	input  word_t  reg1_i,
	input  word_t  reg2_i,
	output word_t  res_o,
	output logic   ov_o
);

	logic  sub_op;
	word_t reg2_mux;
	word_t sum;
	logic  lt_signed;
	logic  lt_unsigned;

	// leading zero count, 32 for an all-zero word.
	function automatic word_t lead_zeros(input word_t v);
		word_t n;
		n = word_t'(`EX_WORD_W);
		// lowest to highest, the top set bit wins.
		for (int i = 0; i < `EX_WORD_W; i++)
		begin
			if (v[i])
				n = word_t'(`EX_WORD_W - 1 - i);
		end
		return n;
	endfunction

	// subtract and signed compare use the negated reg2.
	assign sub_op   = op_i inside {OP_SUB, OP_SUBU, OP_SLT};
	assign reg2_mux = sub_op ? (~reg2_i + 1'b1) : reg2_i;

	// one shared adder.
	assign sum = reg1_i + reg2_mux;

	// same operand signs but a flipped result sign.
	assign ov_o = (reg1_i[`EX_WORD_W-1] == reg2_mux[`EX_WORD_W-1])
		&& (sum[`EX_WORD_W-1] != reg1_i[`EX_WORD_W-1]);

	// negative vs positive, or equal signs and a negative difference.
	assign lt_signed = (reg1_i[`EX_WORD_W-1] && !reg2_i[`EX_WORD_W-1])
		|| ((reg1_i[`EX_WORD_W-1] == reg2_i[`EX_WORD_W-1]) && sum[`EX_WORD_W-1]);
	assign lt_unsigned = reg1_i < reg2_i;

	always_comb
	begin
		case (op_i)
			OP_ADD, OP_ADDU, OP_SUB, OP_SUBU: res_o = sum;
			OP_SLT: res_o = word_t'(lt_signed);
			OP_SLTU: res_o = word_t'(lt_unsigned);
			OP_CLZ: res_o = lead_zeros(reg1_i);
			// leading ones are leading zeros of the inverse.
			OP_CLO: res_o = lead_zeros(~reg1_i);
			default: res_o = '0;
		endcase
	end

endmodule

/* ex_logic_shift.sv */
`timescale 1ns/1ps
`include "ex_defines.svh"

module ex_logic_shift import ex_pkg::*;
(
	input  ex_op_e op_i,
	input  word_t  reg1_i,
	input  word_t  reg2_i,
	output word_t  res_o
);

	logic [`EX_SHAMT_W-1:0] shamt;

	// shift amount from the low bits of reg1.
	assign shamt = reg1_i[`EX_SHAMT_W-1:0];

	always_comb
	begin
		case (op_i)
			// bitwise logic.
			OP_OR: res_o = reg1_i | reg2_i;
			OP_AND: res_o = reg1_i & reg2_i;
			OP_NOR: res_o = ~(reg1_i | reg2_i);
			OP_XOR: res_o = reg1_i ^ reg2_i;
			// shifts act on reg2.
			OP_SLL: res_o = reg2_i << shamt;
			OP_SRL: res_o = reg2_i >> shamt;
			// sign bit fills from the top.
			OP_SRA: res_o = word_t'($signed(reg2_i) >>> shamt);
			default: res_o = '0;
		endcase
	end

endmodule

/* ex_pkg.sv */
`include "ex_defines.svh"

package ex_pkg;

	// basic data types.
	typedef logic [`EX_WORD_W-1:0] word_t;
	typedef logic [`EX_DWORD_W-1:0] dword_t;
	typedef logic [`EX_REG_ADDR_W-1:0] reg_addr_t;

	// opcodes after decode.
	// immediate forms are folded into these.
	typedef enum logic [4:0] {
		OP_NOP, OP_OR, OP_AND, OP_NOR, OP_XOR,
		OP_SLL, OP_SRL, OP_SRA,
		OP_ADD, OP_ADDU, OP_SUB, OP_SUBU,
		OP_SLT, OP_SLTU, OP_CLZ, OP_CLO,
		OP_MUL, OP_MULT, OP_MULTU,
		OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU,
		OP_MFHI, OP_MFLO, OP_MTHI, OP_MTLO
	} ex_op_e;

	// result group for the wdata mux.
	typedef enum logic [2:0] {
		GRP_NONE, GRP_LOGIC, GRP_SHIFT, GRP_ARITH, GRP_MUL, GRP_MOVE
	} ex_grp_e;

	// control fsm states.
	typedef enum logic [1:0] {
		ST_IDLE, ST_EXEC, ST_ACC, ST_DONE
	} ex_state_e;

	// request from the decode side.
	typedef struct packed {
		ex_op_e    op;
		word_t     reg1;
		word_t     reg2;
		reg_addr_t wd;
		logic      wreg;
	} ex_req_t;

	// response towards the next stage.
	typedef struct packed {
		word_t     wdata;
		reg_addr_t wd;
		logic      wreg;
		logic      ov;
	} ex_rsp_t;

	// hi word first.
	typedef struct packed {
		word_t hi;
		word_t lo;
	} hilo_t;

endpackage

/* ex_defines.svh */
`ifndef EX_DEFINES_SVH
`define EX_DEFINES_SVH

// *************************************************************************
// datapath widths of the execute unit.
// *************************************************************************

// one general purpose register word.
`define EX_WORD_W 32

// full product and the hi/lo pair.
`define EX_DWORD_W 64

// destination register index.
`define EX_REG_ADDR_W 5

// shift amount taken from the low bits of reg1.
`define EX_SHAMT_W 5

`endif
